// ==== hw/rs_pkg.sv ====
`default_nettype none

package rs_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    localparam int rs_depth       = 8;
    localparam int dispatch_width = 2;
    localparam int cdb_width      = 2;
    localparam int num_alu        = 2;
    localparam int num_mult       = 1;
    localparam int tag_bits       = 6;
    localparam int br_bits        = 4;
    localparam int payload_bits   = 16;

    ////////////////////////////////////////
    // scalar types
    ////////////////////////////////////////

    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [br_bits-1:0] br_mask_t;
    typedef logic [$clog2(rs_depth+1)-1:0] count_t;
    typedef logic [$clog2(dispatch_width+1)-1:0] open_t;

    typedef enum logic {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_class_e;

    typedef enum logic [1:0] {
        br_none   = 2'd0,
        br_squash = 2'd1,
        br_clear  = 2'd2
    } br_op_e;

    ////////////////////////////////////////
    // packets
    ////////////////////////////////////////

    typedef struct packed {
        tag_t tag;
        logic ready;
    } src_t;

    // one renamed instruction from the rename stage
    typedef struct packed {
        logic                    valid;
        fu_class_e               fu_class;
        tag_t                    dest;
        src_t                    src1;
        src_t                    src2;
        logic [payload_bits-1:0] payload;
    } dispatch_t;

    // stored form, plus the branches it still depends on
    typedef struct packed {
        dispatch_t inst;
        br_mask_t  br_mask;
    } entry_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } cdb_t;

    typedef struct packed {
        br_op_e   op;
        br_mask_t mask;
    } br_resolve_t;

endpackage

`default_nettype wire

// ==== hw/rs_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_ctrl (
    input  logic                                           clock,
    input  logic                                           reset,
    input  rs_pkg::dispatch_t [rs_pkg::dispatch_width-1:0] dispatch,
    input  rs_pkg::br_mask_t  [rs_pkg::rs_depth-1:0]       entry_masks,
    input  logic              [rs_pkg::rs_depth-1:0]       entry_valid,
    input  logic              [rs_pkg::rs_depth-1:0]       issued,
    input  rs_pkg::br_mask_t                               new_branch,
    input  rs_pkg::br_resolve_t                            br_resolve,
    output logic              [rs_pkg::rs_depth-1:0]       kill,
    output rs_pkg::br_mask_t                               clear_mask,
    output rs_pkg::br_mask_t                               dispatch_mask,
    output rs_pkg::open_t                                  open_entries
);

    rs_pkg::count_t   count;
    rs_pkg::count_t   count_next;
    rs_pkg::count_t   free_slots;
    rs_pkg::br_mask_t br_mask;
    rs_pkg::br_mask_t resolved;

    ////////////////////////////////////////
    // branch state
    ////////////////////////////////////////

    // a resolved branch leaves the mask whether squashed or cleared
    assign resolved      = (br_resolve.op != rs_pkg::br_none) ? br_resolve.mask : '0;
    assign dispatch_mask = (br_mask | new_branch) & ~resolved;
    assign clear_mask    = (br_resolve.op == rs_pkg::br_clear) ? br_resolve.mask : '0;

    always_comb begin
        for (int i = 0; i < rs_pkg::rs_depth; i++) begin
            kill[i] = entry_valid[i] && (br_resolve.op == rs_pkg::br_squash) &&
                      ((entry_masks[i] & br_resolve.mask) != '0);
        end
    end

    ////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////

    always_comb begin
        count_next = count;
        // grants never overlap kills, so one decrement per slot
        for (int i = 0; i < rs_pkg::rs_depth; i++) begin
            if (kill[i] || issued[i]) begin
                count_next = count_next - rs_pkg::count_t'(1);
            end
        end
        for (int l = 0; l < rs_pkg::dispatch_width; l++) begin
            if (dispatch[l].valid) begin
                count_next = count_next + rs_pkg::count_t'(1);
            end
        end
    end

    assign free_slots   = rs_pkg::count_t'(rs_pkg::rs_depth) - count;
    assign open_entries = (free_slots > rs_pkg::count_t'(rs_pkg::dispatch_width)) ?
                          rs_pkg::open_t'(rs_pkg::dispatch_width) :
                          rs_pkg::open_t'(free_slots);

    always_ff @(posedge clock) begin
        if (reset) begin
            count   <= '0;
            br_mask <= '0;
        end else begin
            count   <= count_next;
            br_mask <= dispatch_mask;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rs_entry_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_entry_array (
    input  logic                                           clock,
    input  logic                                           reset,
    input  rs_pkg::dispatch_t [rs_pkg::dispatch_width-1:0] dispatch,
    input  logic [rs_pkg::dispatch_width-1:0][rs_pkg::rs_depth-1:0] slot_sel,
    input  rs_pkg::br_mask_t                               dispatch_mask,
    input  rs_pkg::cdb_t      [rs_pkg::cdb_width-1:0]      cdb,
    input  logic              [rs_pkg::rs_depth-1:0]       kill,
    input  rs_pkg::br_mask_t                               clear_mask,
    input  logic              [rs_pkg::rs_depth-1:0]       alu_grant,
    input  logic              [rs_pkg::rs_depth-1:0]       mult_grant,
    output rs_pkg::entry_t    [rs_pkg::rs_depth-1:0]       entries,
    output logic              [rs_pkg::rs_depth-1:0]       entry_valid,
    output rs_pkg::br_mask_t  [rs_pkg::rs_depth-1:0]       entry_masks
);

    rs_pkg::entry_t [rs_pkg::rs_depth-1:0] slots;
    rs_pkg::entry_t [rs_pkg::rs_depth-1:0] slots_next;
    logic           [rs_pkg::rs_depth-1:0] valid;
    logic           [rs_pkg::rs_depth-1:0] valid_next;

    // marks a source ready when any broadcast carries its tag
    function automatic rs_pkg::src_t wake(
        input rs_pkg::src_t                         src,
        input rs_pkg::cdb_t [rs_pkg::cdb_width-1:0] bus
    );
        rs_pkg::src_t woken;
        woken = src;
        for (int j = 0; j < rs_pkg::cdb_width; j++) begin
            if (bus[j].valid && (bus[j].tag == src.tag)) begin
                woken.ready = 1'b1;
            end
        end
        return woken;
    endfunction

    ////////////////////////////////////////
    // woken view of stored entries
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < rs_pkg::rs_depth; i++) begin
            entries[i]            = slots[i];
            entries[i].inst.valid = valid[i];
            entries[i].inst.src1  = wake(slots[i].inst.src1, cdb);
            entries[i].inst.src2  = wake(slots[i].inst.src2, cdb);
            entry_masks[i]        = slots[i].br_mask;
        end
    end

    assign entry_valid = valid;

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb begin
        // squash and issue both free the slot
        valid_next = valid & ~kill & ~alu_grant & ~mult_grant;

        // wakeups stick, resolved branch bits drop out
        for (int i = 0; i < rs_pkg::rs_depth; i++) begin
            slots_next[i]         = entries[i];
            slots_next[i].br_mask = entries[i].br_mask & ~clear_mask;
        end

        // dispatch writes go last
        for (int l = 0; l < rs_pkg::dispatch_width; l++) begin
            for (int i = 0; i < rs_pkg::rs_depth; i++) begin
                if (dispatch[l].valid && slot_sel[l][i]) begin
                    valid_next[i]         = 1'b1;
                    slots_next[i].inst    = dispatch[l];
                    // catch a tag broadcast in the same cycle as dispatch
                    slots_next[i].inst.src1 = wake(dispatch[l].src1, cdb);
                    slots_next[i].inst.src2 = wake(dispatch[l].src2, cdb);
                    slots_next[i].br_mask = dispatch_mask;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            valid <= valid_next;
        end
    end

    always_ff @(posedge clock) begin
        slots <= slots_next;
    end

endmodule

`default_nettype wire

// ==== hw/rs_dispatch_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_dispatch_sel (
    input  logic [rs_pkg::rs_depth-1:0]                             entry_valid,
    output logic [rs_pkg::dispatch_width-1:0][rs_pkg::rs_depth-1:0] slot_sel
);

    logic [rs_pkg::rs_depth-1:0] taken;
    logic                        found;

    // lowest free slot per lane, each lane marks its pick as taken
    always_comb begin
        taken    = entry_valid;
        slot_sel = '0;
        found    = 1'b0;
        for (int l = 0; l < rs_pkg::dispatch_width; l++) begin
            found = 1'b0;
            for (int i = 0; i < rs_pkg::rs_depth; i++) begin
                if (!taken[i] && !found) begin
                    slot_sel[l][i] = 1'b1;
                    taken[i]       = 1'b1;
                    found          = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/rs_issue_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_issue_sel #(
    parameter rs_pkg::fu_class_e unit_class = rs_pkg::fu_alu,
    parameter int                num_units  = 1
) (
    input  rs_pkg::entry_t [rs_pkg::rs_depth-1:0] entries,
    input  logic           [rs_pkg::rs_depth-1:0] kill,
    input  logic           [num_units-1:0]        busy,
    output logic           [rs_pkg::rs_depth-1:0] grant,
    output rs_pkg::entry_t [num_units-1:0]        issue
);

    logic [rs_pkg::rs_depth-1:0] req;
    logic [rs_pkg::rs_depth-1:0] pending;
    logic                        found;

    // ready entries of this class that survive the squash
    always_comb begin
        for (int i = 0; i < rs_pkg::rs_depth; i++) begin
            req[i] = entries[i].inst.valid && !kill[i] &&
                     (entries[i].inst.fu_class == unit_class) &&
                     entries[i].inst.src1.ready && entries[i].inst.src2.ready;
        end
    end

    ////////////////////////////////////////
    // in-order grant to free units
    ////////////////////////////////////////

    always_comb begin
        pending = req;
        grant   = '0;
        issue   = '0;
        found   = 1'b0;
        for (int u = 0; u < num_units; u++) begin
            found = 1'b0;
            // busy units skip their turn, requests move on
            if (!busy[u]) begin
                for (int i = 0; i < rs_pkg::rs_depth; i++) begin
                    if (pending[i] && !found) begin
                        found      = 1'b1;
                        pending[i] = 1'b0;
                        grant[i]   = 1'b1;
                        issue[u]   = entries[i];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/rs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rs_top (
    input  logic                                           clock,
    input  logic                                           reset,
    input  rs_pkg::dispatch_t [rs_pkg::dispatch_width-1:0] dispatch,
    input  rs_pkg::br_mask_t                               new_branch,
    input  rs_pkg::cdb_t      [rs_pkg::cdb_width-1:0]      cdb,
    input  rs_pkg::br_resolve_t                            br_resolve,
    input  logic              [rs_pkg::num_alu-1:0]        alu_busy,
    input  logic              [rs_pkg::num_mult-1:0]       mult_busy,
    output rs_pkg::entry_t    [rs_pkg::num_alu-1:0]        issue_alu,
    output rs_pkg::entry_t    [rs_pkg::num_mult-1:0]       issue_mult,
    output rs_pkg::open_t                                  open_entries
);

    rs_pkg::entry_t   [rs_pkg::rs_depth-1:0] entries;
    logic             [rs_pkg::rs_depth-1:0] entry_valid;
    rs_pkg::br_mask_t [rs_pkg::rs_depth-1:0] entry_masks;
    logic             [rs_pkg::rs_depth-1:0] kill;
    logic             [rs_pkg::rs_depth-1:0] alu_grant;
    logic             [rs_pkg::rs_depth-1:0] mult_grant;
    rs_pkg::br_mask_t                        clear_mask;
    rs_pkg::br_mask_t                        dispatch_mask;
    logic [rs_pkg::dispatch_width-1:0][rs_pkg::rs_depth-1:0] slot_sel;

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    rs_ctrl i_ctrl (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .entry_masks   (entry_masks),
        .entry_valid   (entry_valid),
        .issued        (alu_grant | mult_grant),
        .new_branch    (new_branch),
        .br_resolve    (br_resolve),
        .kill          (kill),
        .clear_mask    (clear_mask),
        .dispatch_mask (dispatch_mask),
        .open_entries  (open_entries)
    );

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    rs_entry_array i_entry_array (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .slot_sel      (slot_sel),
        .dispatch_mask (dispatch_mask),
        .cdb           (cdb),
        .kill          (kill),
        .clear_mask    (clear_mask),
        .alu_grant     (alu_grant),
        .mult_grant    (mult_grant),
        .entries       (entries),
        .entry_valid   (entry_valid),
        .entry_masks   (entry_masks)
    );

    rs_dispatch_sel i_dispatch_sel (
        .entry_valid (entry_valid),
        .slot_sel    (slot_sel)
    );

    rs_issue_sel #(
        .unit_class (rs_pkg::fu_alu),
        .num_units  (rs_pkg::num_alu)
    ) alu_sel (
        .entries (entries),
        .kill    (kill),
        .busy    (alu_busy),
        .grant   (alu_grant),
        .issue   (issue_alu)
    );

    rs_issue_sel #(
        .unit_class (rs_pkg::fu_mult),
        .num_units  (rs_pkg::num_mult)
    ) mult_sel (
        .entries (entries),
        .kill    (kill),
        .busy    (mult_busy),
        .grant   (mult_grant),
        .issue   (issue_mult)
    );

endmodule

`default_nettype wire

// ==== dv/tb_rs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rs;

    // scoreboard record, indexed by the low payload bits
    typedef struct packed {
        logic                            valid;
        logic                            issued;
        logic                            doomed;
        rs_pkg::fu_class_e               fu_class;
        rs_pkg::tag_t                    dest;
        rs_pkg::tag_t                    tag1;
        rs_pkg::tag_t                    tag2;
        logic                            rdy1;
        logic                            rdy2;
        rs_pkg::br_mask_t                mask;
        logic [rs_pkg::payload_bits-1:0] payload;
    } sb_entry_t;

    logic                                             clock;
    logic                                             reset;
    rs_pkg::dispatch_t   [rs_pkg::dispatch_width-1:0] dispatch;
    rs_pkg::br_mask_t                                 new_branch;
    rs_pkg::cdb_t        [rs_pkg::cdb_width-1:0]      cdb;
    rs_pkg::br_resolve_t                              br_resolve;
    logic                [rs_pkg::num_alu-1:0]        alu_busy;
    logic                [rs_pkg::num_mult-1:0]       mult_busy;
    rs_pkg::entry_t      [rs_pkg::num_alu-1:0]        issue_alu;
    rs_pkg::entry_t      [rs_pkg::num_mult-1:0]       issue_mult;
    rs_pkg::open_t                                    open_entries;

    sb_entry_t         sb [1024];
    sb_entry_t         port_sb [3];
    rs_pkg::entry_t    port_pkt [3];
    logic              port_busy [3];
    logic              src_ready [3];
    logic              doomed_now [3];
    rs_pkg::fu_class_e port_class [3] = '{rs_pkg::fu_alu, rs_pkg::fu_alu, rs_pkg::fu_mult};
    rs_pkg::open_t     exp_open;
    rs_pkg::br_mask_t  tb_mask;
    logic [31:0]       lfsr;
    int                occ;
    int                next_id;
    int                sweep_tag;
    int                cycle_count = 0;
    logic              started;
    logic              saw_full;
    logic              drained;
    logic              gen_dispatch;
    logic              gen_mult_only;
    logic              gen_cdb;
    logic              gen_branches;
    logic              busy_random;
    logic              hold_mult;
    logic              sweep;

    rs_top i_dut (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .new_branch   (new_branch),
        .cdb          (cdb),
        .br_resolve   (br_resolve),
        .alu_busy     (alu_busy),
        .mult_busy    (mult_busy),
        .issue_alu    (issue_alu),
        .issue_mult   (issue_mult),
        .open_entries (open_entries)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 2000) begin
            $display("timeout: the run did not finish within 2000 cycles");
            abort_run();
        end
    end

    ////////////////////////////////////////
    // failure reporting
    ////////////////////////////////////////

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("ERROR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic plain_failure(input string msg);
        $display("%0t %s", $time, msg);
        abort_run();
    endtask

    function automatic string port_name(input int p);
        return (p < 2) ? $sformatf("issue_alu[%0d]", p) : "issue_mult[0]";
    endfunction

    ////////////////////////////////////////
    // random source
    ////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic tag_on_cdb(input rs_pkg::tag_t tag,
                                        input rs_pkg::cdb_t [rs_pkg::cdb_width-1:0] bus);
        logic hit;
        hit = 1'b0;
        for (int c = 0; c < rs_pkg::cdb_width; c++) begin
            if (bus[c].valid && (bus[c].tag == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // free slots reported for a given occupancy, capped at the lane count
    function automatic rs_pkg::open_t open_slots(input int occupancy);
        int room_left;
        room_left = rs_pkg::rs_depth - occupancy;
        return (room_left > rs_pkg::dispatch_width) ?
               rs_pkg::open_t'(rs_pkg::dispatch_width) :
               rs_pkg::open_t'(room_left);
    endfunction

    ////////////////////////////////////////
    // expected view of each issue port
    ////////////////////////////////////////

    assign port_pkt[0]  = issue_alu[0];
    assign port_pkt[1]  = issue_alu[1];
    assign port_pkt[2]  = issue_mult[0];
    assign port_busy[0] = alu_busy[0];
    assign port_busy[1] = alu_busy[1];
    assign port_busy[2] = mult_busy[0];

    always_comb begin
        for (int p = 0; p < 3; p++) begin
            port_sb[p]    = sb[port_pkt[p].inst.payload[9:0]];
            src_ready[p]  = (port_sb[p].rdy1 || tag_on_cdb(port_sb[p].tag1, cdb)) &&
                            (port_sb[p].rdy2 || tag_on_cdb(port_sb[p].tag2, cdb));
            // a squash in this cycle already blocks issue
            doomed_now[p] = port_sb[p].doomed ||
                            ((br_resolve.op == rs_pkg::br_squash) &&
                             ((port_sb[p].mask & br_resolve.mask) != '0));
        end
        exp_open = open_slots(occ);
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    for (genvar p = 0; p < 3; p++) begin : g_port
        assert property (@(posedge clock) disable iff (reset)
            port_pkt[p].inst.valid |-> port_sb[p].valid && !port_sb[p].issued)
        else plain_failure($sformatf("%s issued a payload not waiting in the station",
                                     port_name(p)));
        assert property (@(posedge clock) disable iff (reset)
            port_pkt[p].inst.valid |-> port_sb[p].fu_class == port_class[p])
        else value_mismatch($sformatf("%s.inst.fu_class", port_name(p)),
                            32'($sampled(port_class[p])), 32'($sampled(port_sb[p].fu_class)));
        assert property (@(posedge clock) disable iff (reset)
            port_pkt[p].inst.valid |-> port_pkt[p].inst.payload == port_sb[p].payload)
        else value_mismatch($sformatf("%s.inst.payload", port_name(p)),
                            32'($sampled(port_sb[p].payload)),
                            32'($sampled(port_pkt[p].inst.payload)));
        assert property (@(posedge clock) disable iff (reset)
            port_pkt[p].inst.valid |-> port_pkt[p].inst.dest == port_sb[p].dest)
        else value_mismatch($sformatf("%s.inst.dest", port_name(p)),
                            32'($sampled(port_sb[p].dest)),
                            32'($sampled(port_pkt[p].inst.dest)));
        assert property (@(posedge clock) disable iff (reset)
            port_pkt[p].inst.valid |->
            {port_pkt[p].inst.src1.tag, port_pkt[p].inst.src2.tag} ==
            {port_sb[p].tag1, port_sb[p].tag2})
        else value_mismatch($sformatf("%s.inst.src1/src2 tags", port_name(p)),
                            32'({$sampled(port_sb[p].tag1), $sampled(port_sb[p].tag2)}),
                            32'({$sampled(port_pkt[p].inst.src1.tag),
                                 $sampled(port_pkt[p].inst.src2.tag)}));
        assert property (@(posedge clock) disable iff (reset)
            port_pkt[p].inst.valid |-> port_pkt[p].br_mask == port_sb[p].mask)
        else value_mismatch($sformatf("%s.br_mask", port_name(p)),
                            32'($sampled(port_sb[p].mask)),
                            32'($sampled(port_pkt[p].br_mask)));
        assert property (@(posedge clock) disable iff (reset)
            port_pkt[p].inst.valid |-> src_ready[p])
        else plain_failure($sformatf("%s issued before its source tags were broadcast",
                                     port_name(p)));
        assert property (@(posedge clock) disable iff (reset)
            port_pkt[p].inst.valid |-> !doomed_now[p])
        else plain_failure($sformatf("%s issued a squashed entry", port_name(p)));
        assert property (@(posedge clock) disable iff (reset)
            port_pkt[p].inst.valid |-> !port_busy[p])
        else plain_failure($sformatf("%s issued while its unit was busy", port_name(p)));
    end

    assert property (@(posedge clock) disable iff (reset)
        port_pkt[0].inst.valid && port_pkt[1].inst.valid |->
        port_pkt[0].inst.payload != port_pkt[1].inst.payload)
    else plain_failure("both ALU ports issued the same payload");

    assert property (@(posedge clock) disable iff (reset)
        !started |-> !(port_pkt[0].inst.valid || port_pkt[1].inst.valid ||
                       port_pkt[2].inst.valid))
    else plain_failure("an issue port was valid before any dispatch");

    assert property (@(posedge clock) disable iff (reset) open_entries == exp_open)
    else value_mismatch("open_entries", 32'($sampled(exp_open)), 32'($sampled(open_entries)));

    assert property (@(posedge clock) disable iff (reset) drained |-> occ == 0)
    else value_mismatch("occupancy after drain", 32'd0, 32'($sampled(occ)));

    assert property (@(posedge clock) disable iff (reset) drained |-> saw_full)
    else plain_failure("open_entries never reached zero while the station was full");

    ////////////////////////////////////////
    // bookkeeping of the cycle just ended
    ////////////////////////////////////////

    task automatic record_cycle();
        logic [9:0]       id;
        rs_pkg::br_mask_t resolved;
        int               added;
        int               gone;
        added    = 0;
        gone     = 0;
        resolved = (br_resolve.op != rs_pkg::br_none) ? br_resolve.mask : '0;
        for (int l = 0; l < rs_pkg::dispatch_width; l++) begin
            if (dispatch[l].valid) begin
                id              = dispatch[l].payload[9:0];
                sb[id].valid    = 1'b1;
                sb[id].fu_class = dispatch[l].fu_class;
                sb[id].dest     = dispatch[l].dest;
                sb[id].tag1     = dispatch[l].src1.tag;
                sb[id].tag2     = dispatch[l].src2.tag;
                sb[id].rdy1     = dispatch[l].src1.ready;
                sb[id].rdy2     = dispatch[l].src2.ready;
                sb[id].mask     = (tb_mask | new_branch) & ~resolved;
                sb[id].payload  = dispatch[l].payload;
                added           = added + 1;
            end
        end
        // wakeup covers entries dispatched in the same cycle
        for (int i = 0; i < 1024; i++) begin
            if (sb[i].valid && !sb[i].issued) begin
                sb[i].rdy1 = sb[i].rdy1 || tag_on_cdb(sb[i].tag1, cdb);
                sb[i].rdy2 = sb[i].rdy2 || tag_on_cdb(sb[i].tag2, cdb);
            end
        end
        for (int p = 0; p < 3; p++) begin
            if (port_pkt[p].inst.valid) begin
                sb[port_pkt[p].inst.payload[9:0]].issued = 1'b1;
                gone = gone + 1;
            end
        end
        for (int i = 0; i < 1024; i++) begin
            if ((br_resolve.op == rs_pkg::br_squash) && sb[i].valid && !sb[i].issued &&
                !sb[i].doomed && ((sb[i].mask & br_resolve.mask) != '0)) begin
                sb[i].doomed = 1'b1;
                gone         = gone + 1;
            end
            if (br_resolve.op == rs_pkg::br_clear) begin
                sb[i].mask = sb[i].mask & ~br_resolve.mask;
            end
        end
        occ     = occ + added - gone;
        tb_mask = (tb_mask | new_branch) & ~resolved;
        if (open_entries == '0) begin
            saw_full = 1'b1;
        end
    endtask

    ////////////////////////////////////////
    // stimulus for the next cycle
    ////////////////////////////////////////

    task automatic make_inst(output rs_pkg::dispatch_t d);
        logic [31:0] v;
        d       = '0;
        d.valid = 1'b1;
        rand_bits(2, v);
        d.fu_class = (gen_mult_only || (v[1:0] == 2'd0)) ? rs_pkg::fu_mult : rs_pkg::fu_alu;
        rand_bits(6, v);
        d.dest = v[5:0];
        rand_bits(6, v);
        d.src1.tag = v[5:0];
        rand_bits(2, v);
        d.src1.ready = gen_mult_only || (v[1:0] != 2'd0);
        rand_bits(6, v);
        d.src2.tag = v[5:0];
        rand_bits(2, v);
        d.src2.ready = gen_mult_only || (v[1:0] != 2'd0);
        rand_bits(6, v);
        d.payload = {v[5:0], 10'(next_id)};
        next_id   = next_id + 1;
    endtask

    task automatic drive_cycle();
        rs_pkg::dispatch_t   [rs_pkg::dispatch_width-1:0] d;
        rs_pkg::cdb_t        [rs_pkg::cdb_width-1:0]      c;
        rs_pkg::br_resolve_t                              r;
        rs_pkg::br_mask_t                                 nb;
        logic                [rs_pkg::num_alu-1:0]        ab;
        logic                [rs_pkg::num_mult-1:0]       mb;
        logic [31:0]                                      v;
        int                                               room;
        int                                               lanes;
        d     = '0;
        c     = '0;
        r     = '0;
        nb    = '0;
        room  = int'(open_slots(occ));
        lanes = 0;
        if (gen_dispatch) begin
            rand_bits(2, v);
            lanes = (gen_mult_only || int'(v[1:0]) > room) ? room : int'(v[1:0]);
        end
        for (int l = 0; l < lanes; l++) begin
            make_inst(d[l]);
            started = 1'b1;
        end
        for (int k = 0; k < rs_pkg::cdb_width; k++) begin
            rand_bits(7, v);
            c[k].valid = gen_cdb && v[6];
            c[k].tag   = v[5:0];
        end
        // tag sweep wakes every waiting source
        if (sweep) begin
            c[0].valid = 1'b1;
            c[0].tag   = rs_pkg::tag_t'(sweep_tag);
            c[1].valid = 1'b1;
            c[1].tag   = rs_pkg::tag_t'(sweep_tag + 1);
            sweep_tag  = sweep_tag + 2;
        end
        if (gen_branches) begin
            rand_bits(5, v);
            if ((v[4:2] == 3'd0) && !tb_mask[v[1:0]]) begin
                nb[v[1:0]] = 1'b1;
            end
            rand_bits(6, v);
            if ((v[5:3] == 3'd0) && tb_mask[v[1:0]]) begin
                r.op         = v[2] ? rs_pkg::br_squash : rs_pkg::br_clear;
                r.mask[v[1:0]] = 1'b1;
            end
        end
        for (int u = 0; u < rs_pkg::num_alu; u++) begin
            rand_bits(2, v);
            ab[u] = busy_random && (v[1:0] == 2'b11);
        end
        rand_bits(2, v);
        mb[0] = hold_mult || (busy_random && (v[1:0] == 2'b11));
        dispatch   <= d;
        cdb        <= c;
        br_resolve <= r;
        new_branch <= nb;
        alu_busy   <= ab;
        mult_busy  <= mb;
    endtask

    task automatic step_cycle();
        @(posedge clock);
        record_cycle();
        drive_cycle();
    endtask

    initial begin
        int tries;
        clock         = 1'b0;
        reset         = 1'b1;
        dispatch      = '0;
        new_branch    = '0;
        cdb           = '0;
        br_resolve    = '0;
        alu_busy      = '0;
        mult_busy     = '0;
        lfsr          = 32'h4d6b;
        tb_mask       = '0;
        occ           = 0;
        next_id       = 0;
        sweep_tag     = 0;
        started       = 1'b0;
        saw_full      = 1'b0;
        drained       = 1'b0;
        gen_dispatch  = 1'b0;
        gen_mult_only = 1'b0;
        gen_cdb       = 1'b0;
        gen_branches  = 1'b0;
        busy_random   = 1'b0;
        hold_mult     = 1'b0;
        sweep         = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            sb[i] = '0;
        end
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        repeat (5) step_cycle();

        // mixed traffic with wakeups, busy units and branches
        gen_dispatch = 1'b1;
        gen_cdb      = 1'b1;
        gen_branches = 1'b1;
        busy_random  = 1'b1;
        repeat (250) step_cycle();

        // fill with blocked multiplies
        gen_cdb       = 1'b0;
        gen_branches  = 1'b0;
        busy_random   = 1'b0;
        gen_mult_only = 1'b1;
        hold_mult     = 1'b1;
        tries         = 0;
        while ((occ < rs_pkg::rs_depth) && (tries < 40)) begin
            step_cycle();
            tries = tries + 1;
        end
        gen_dispatch = 1'b0;
        repeat (4) step_cycle();

        // drain
        hold_mult = 1'b0;
        sweep     = 1'b1;
        repeat (32) step_cycle();
        sweep = 1'b0;
        repeat (20) step_cycle();
        drained = 1'b1;
        repeat (2) step_cycle();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hw/rs_pkg.sv
hw/rs_ctrl.sv
hw/rs_entry_array.sv
hw/rs_dispatch_sel.sv
hw/rs_issue_sel.sv
hw/rs_top.sv
dv/tb_rs.sv

// ==== Makefile ====
TOP := tb_rs

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module rs_top hw/rs_pkg.sv hw/rs_ctrl.sv \
		hw/rs_entry_array.sv hw/rs_dispatch_sel.sv hw/rs_issue_sel.sv hw/rs_top.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
